// File: dv/oc_tb.sv
`timescale 1ns/1ps

module oc_tb import oc_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        wb_valid;
    warp_t       wb_warp;
    reg_t        wb_reg;
    vec_t        wb_data;
    mask_t       wb_mask;
    logic        issue_valid;
    warp_t       issue_warp;
    reg_t        issue_src1;
    logic        issue_src1_valid;
    reg_t        issue_src2;
    logic        issue_src2_valid;
    reg_t        issue_dst;
    alu_op_t     issue_alu_op;
    logic [15:0] issue_imm;
    logic        issue_imm_valid;
    mask_t       issue_mask;
    logic        collectors_full;
    logic        alu_valid;
    warp_t       alu_warp;
    reg_t        alu_dst;
    alu_op_t     alu_op;
    logic [15:0] alu_imm;
    logic        alu_imm_valid;
    mask_t       alu_mask;
    vec_t        alu_src1;
    vec_t        alu_src2;

    vec_t   model [num_warps][regs_per_warp];   // reference register contents
    instr_t exp_instr [regs_per_warp];          // expected results, keyed by dst
    reg_t   exp_s1 [regs_per_warp];
    reg_t   exp_s2 [regs_per_warp];
    logic   exp_v1 [regs_per_warp];
    logic   exp_v2 [regs_per_warp];
    logic   outstanding [regs_per_warp];
    int     seed;

    operand_collector_top #(.NUM_COLLECTORS(4)) dut (.*);

    always #2 clk = ~clk;

    task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
        if (got !== exp) begin
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic rand_vec(output vec_t v);
        for (int l = 0; l < num_lanes; l++) begin
            v[l*lane_w +: lane_w] = $random(seed);
        end
    endtask

    task automatic write_reg(input warp_t w, input reg_t r, input vec_t d, input mask_t m);
        wb_valid = 1'b1;
        wb_warp  = w;
        wb_reg   = r;
        wb_data  = d;
        wb_mask  = m;
        for (int l = 0; l < num_lanes; l++) begin
            if (m[l]) begin
                model[w][r][l*lane_w +: lane_w] = d[l*lane_w +: lane_w];
            end
        end
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic expect_instr(input warp_t w, input reg_t s1, input logic v1, input reg_t s2,
                                input logic v2, input reg_t d, input alu_op_t op,
                                input logic [15:0] imm, input logic immv, input mask_t m);
        exp_instr[d] = '{warp: w, dst: d, alu_op: op, imm: imm, imm_valid: immv, mask: m};
        exp_s1[d]      = s1;
        exp_v1[d]      = v1;
        exp_s2[d]      = s2;
        exp_v2[d]      = v2;
        outstanding[d] = 1'b1;
    endtask

    task automatic issue(input reg_t d);
        issue_valid      = 1'b1;
        issue_warp       = exp_instr[d].warp;
        issue_src1       = exp_s1[d];
        issue_src1_valid = exp_v1[d];
        issue_src2       = exp_s2[d];
        issue_src2_valid = exp_v2[d];
        issue_dst        = d;
        issue_alu_op     = exp_instr[d].alu_op;
        issue_imm        = exp_instr[d].imm;
        issue_imm_valid  = exp_instr[d].imm_valid;
        issue_mask       = exp_instr[d].mask;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic wait_alu;
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!alu_valid && n < 50);
        if (!alu_valid) stop_run("no dispatch arrived on the ALU port within 50 cycles");
    endtask

    // unused sources read as zero
    task automatic check_alu_out;
        reg_t d;
        vec_t exp1;
        vec_t exp2;
        d = alu_dst;
        if (!outstanding[d]) stop_run("ALU port carried a dst that was not outstanding");
        outstanding[d] = 1'b0;
        exp1 = exp_v1[d] ? model[exp_instr[d].warp][exp_s1[d]] : '0;
        exp2 = exp_v2[d] ? model[exp_instr[d].warp][exp_s2[d]] : '0;
        check(vec_t'(alu_warp), vec_t'(exp_instr[d].warp), "alu_warp");
        check(vec_t'(alu_op), vec_t'(exp_instr[d].alu_op), "alu_op");
        check(vec_t'(alu_imm), vec_t'(exp_instr[d].imm), "alu_imm");
        check(vec_t'(alu_imm_valid), vec_t'(exp_instr[d].imm_valid), "alu_imm_valid");
        check(vec_t'(alu_mask), vec_t'(exp_instr[d].mask), "alu_mask");
        check(alu_src1, exp1, "alu_src1");
        check(alu_src2, exp2, "alu_src2");
    endtask

    task automatic run_one(input reg_t d);
        issue(d);
        wait_alu();
        check_alu_out();
    endtask

    task automatic test_reset;
        check(vec_t'(alu_valid), '0, "alu_valid after reset");
        check(vec_t'(collectors_full), '0, "collectors_full after reset");
    endtask

    task automatic test_basic;
        vec_t a;
        vec_t b;
        rand_vec(a);
        write_reg(2'd1, 3'd2, a, 8'hff);
        rand_vec(b);
        write_reg(2'd1, 3'd3, b, 8'hff);
        expect_instr(2'd1, 3'd2, 1'b1, 3'd3, 1'b1, 3'd5, 4'h3, 16'h1234, 1'b0, 8'hf0);
        run_one(3'd5);
    endtask

    task automatic test_partial;
        vec_t a;
        rand_vec(a);
        write_reg(2'd2, 3'd1, a, 8'hff);
        rand_vec(a);
        write_reg(2'd2, 3'd6, a, 8'hff);
        rand_vec(a);
        write_reg(2'd2, 3'd1, a, 8'h5a);  // only some lanes change
        expect_instr(2'd2, 3'd1, 1'b1, 3'd6, 1'b1, 3'd7, 4'h9, 16'h00a5, 1'b0, 8'hff);
        run_one(3'd7);
    endtask

    task automatic test_same_bank;
        vec_t a;
        rand_vec(a);
        write_reg(2'd3, 3'd0, a, 8'hff);
        rand_vec(a);
        write_reg(2'd3, 3'd4, a, 8'hff);
        expect_instr(2'd3, 3'd0, 1'b1, 3'd4, 1'b1, 3'd2, 4'h1, 16'h0042, 1'b0, 8'h3c);
        run_one(3'd2);
        expect_instr(2'd3, 3'd4, 1'b1, 3'd0, 1'b0, 3'd6, 4'h7, 16'hbeef, 1'b1, 8'hff);
        run_one(3'd6);
    endtask

    // most sources land in bank 1 so the collectors queue up
    task automatic test_burst;
        reg_t s1 [4] = '{3'd1, 3'd0, 3'd3, 3'd2};
        reg_t s2 [4] = '{3'd5, 3'd2, 3'd7, 3'd6};
        vec_t a;
        for (int w = 0; w < 4; w++) begin
            rand_vec(a);
            write_reg(warp_t'(w), s1[w], a, 8'hff);
            rand_vec(a);
            write_reg(warp_t'(w), s2[w], a, 8'hff);
            expect_instr(warp_t'(w), s1[w], 1'b1, s2[w], 1'b1, reg_t'(3 + w),
                         alu_op_t'(w + 1), 16'(256 + w), w[0], mask_t'(8'h0f << w));
        end
        fork
            begin
                for (int w = 0; w < 4; w++) begin
                    issue(reg_t'(3 + w));
                end
                check(vec_t'(collectors_full), vec_t'(1'b1), "collectors_full after 4 issues");
            end
            begin
                repeat (4) begin
                    wait_alu();
                    check_alu_out();
                end
            end
        join
        repeat (8) begin
            @(posedge clk);
            #1;
            check(vec_t'(alu_valid), '0, "alu_valid after the burst drained");
        end
    endtask

    initial begin
        seed             = 84;
        clk              = 1'b0;
        rst_n            = 1'b0;
        wb_valid         = 1'b0;
        wb_warp          = '0;
        wb_reg           = '0;
        wb_data          = '0;
        wb_mask          = '0;
        issue_valid      = 1'b0;
        issue_warp       = '0;
        issue_src1       = '0;
        issue_src1_valid = 1'b0;
        issue_src2       = '0;
        issue_src2_valid = 1'b0;
        issue_dst        = '0;
        issue_alu_op     = '0;
        issue_imm        = '0;
        issue_imm_valid  = 1'b0;
        issue_mask       = '0;
        for (int d = 0; d < regs_per_warp; d++) begin
            outstanding[d] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_basic();
        test_partial();
        test_same_bank();
        test_burst();
        $display("Test OK");
        $finish;
    end

endmodule

// File: flist.f
hw/oc_pkg.sv
hw/oc_req_if.sv
hw/reg_bank.sv
hw/collector_unit.sv
hw/collector_control.sv
hw/dispatch_stage.sv
hw/operand_collector_top.sv
dv/oc_tb.sv

// File: hw/collector_control.sv
`timescale 1ns/1ps

module collector_control import oc_pkg::*; #(
    parameter int NUM_COLLECTORS = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             issue_valid,
    output logic [num_banks-1:0]             rd_en,
    output row_t                             rd_row [num_banks],
    output logic                             collectors_full,
    output logic                             dispatch_valid,
    output logic [idx_w(NUM_COLLECTORS)-1:0] sel,
    oc_req_if.control                        req [NUM_COLLECTORS]
);

    localparam int SEL_W = idx_w(NUM_COLLECTORS);

    logic [NUM_COLLECTORS-1:0]       busy;
    logic [NUM_COLLECTORS-1:0]       ready;
    logic [NUM_COLLECTORS-1:0]       alloc;
    logic [NUM_COLLECTORS-1:0]       dispatch;
    logic [NUM_COLLECTORS-1:0][1:0]  req_valid;
    logic [NUM_COLLECTORS-1:0][1:0]  grant;
    bank_t [NUM_COLLECTORS-1:0][1:0] req_bank;
    row_t  [NUM_COLLECTORS-1:0][1:0] req_row;
    logic [SEL_W-1:0]                rr_ptr;

    for (genvar c = 0; c < NUM_COLLECTORS; c++) begin : g_req
        assign busy[c]         = req[c].busy;
        assign ready[c]        = req[c].ready;
        assign req_valid[c]    = req[c].req_valid;
        assign req_bank[c]     = req[c].req_bank;
        assign req_row[c]      = req[c].req_row;
        assign req[c].alloc    = alloc[c];
        assign req[c].grant    = grant[c];
        assign req[c].dispatch = dispatch[c];
    end

    // lowest free collector takes the issue
    always_comb begin
        logic found;
        found = 1'b0;
        alloc = '0;
        for (int c = 0; c < NUM_COLLECTORS; c++) begin
            if (issue_valid && !busy[c] && !found) begin
                alloc[c] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    // fixed priority per bank, collector first, then slot
    always_comb begin
        grant = '0;
        rd_en = '0;
        for (int b = 0; b < num_banks; b++) begin
            rd_row[b] = '0;
            for (int c = 0; c < NUM_COLLECTORS; c++) begin
                for (int s = 0; s < 2; s++) begin
                    if (!rd_en[b] && req_valid[c][s] && req_bank[c][s] == bank_t'(b)) begin
                        rd_en[b]    = 1'b1;
                        rd_row[b]   = req_row[c][s];
                        grant[c][s] = 1'b1;
                    end
                end
            end
        end
    end

    // round robin over ready collectors, nearest to rr_ptr wins
    always_comb begin
        int idx;
        dispatch_valid = |ready;
        sel            = '0;
        dispatch       = '0;
        for (int i = NUM_COLLECTORS - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_COLLECTORS;
            if (ready[idx]) begin
                sel = SEL_W'(idx);
            end
        end
        if (dispatch_valid) begin
            dispatch[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr          <= '0;
            collectors_full <= 1'b0;
        end else begin
            collectors_full <= &((busy | alloc) & ~dispatch);
            if (dispatch_valid) begin
                rr_ptr <= (sel == SEL_W'(NUM_COLLECTORS - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    a_no_issue_full: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !collectors_full);

    for (genvar b = 0; b < num_banks; b++) begin : g_chk
        logic [2*NUM_COLLECTORS-1:0] hits;
        for (genvar c = 0; c < NUM_COLLECTORS; c++) begin : g_c
            for (genvar s = 0; s < 2; s++) begin : g_s
                assign hits[2*c+s] = grant[c][s] && (req_bank[c][s] == bank_t'(b));
            end
        end
        a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hits));
    end

endmodule

// File: hw/collector_unit.sv
`timescale 1ns/1ps

module collector_unit import oc_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t issue_instr,
    input  reg_t   issue_src1,
    input  logic   issue_src1_valid,
    input  reg_t   issue_src2,
    input  logic   issue_src2_valid,
    input  vec_t   bank_rd_data [num_banks],
    output instr_t instr,
    output vec_t   op1,
    output vec_t   op2,
    oc_req_if.collector req
);

    logic            busy;
    logic [1:0]      filled;
    logic [1:0]      pending;   // granted last cycle, data on bank output now
    bank_t [1:0]     src_bank;
    row_t  [1:0]     src_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            filled  <= '0;
            pending <= '0;
        end else if (req.alloc) begin
            busy    <= 1'b1;
            filled  <= {~issue_src2_valid, ~issue_src1_valid}; // unused source is done
            pending <= '0;
        end else begin
            if (req.dispatch) begin
                busy <= 1'b0;
            end
            filled  <= filled | pending;
            pending <= req.grant;
        end
    end

    always_ff @(posedge clk) begin
        if (req.alloc) begin
            instr       <= issue_instr;
            src_bank[0] <= bank_of(issue_instr.warp, issue_src1);
            src_row[0]  <= row_of(issue_instr.warp, issue_src1);
            src_bank[1] <= bank_of(issue_instr.warp, issue_src2);
            src_row[1]  <= row_of(issue_instr.warp, issue_src2);
            op1         <= '0;
            op2         <= '0;
        end else begin
            if (pending[0]) begin
                op1 <= bank_rd_data[src_bank[0]];
            end
            if (pending[1]) begin
                op2 <= bank_rd_data[src_bank[1]];
            end
        end
    end

    assign req.busy      = busy;
    assign req.ready     = busy && (&filled);
    assign req.req_valid = {2{busy}} & ~filled & ~pending;
    assign req.req_bank  = src_bank;
    assign req.req_row   = src_row;

    // the arbiter must never serve a slot twice
    a_no_regrant: assert property (@(posedge clk) disable iff (!rst_n)
        (req.grant & (filled | pending)) == 2'b00);

endmodule

// File: hw/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage import oc_pkg::*; #(
    parameter int NUM_COLLECTORS = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             dispatch_valid,
    input  logic [idx_w(NUM_COLLECTORS)-1:0] sel,
    input  instr_t                           oc_instr [NUM_COLLECTORS],
    input  vec_t                             oc_op1 [NUM_COLLECTORS],
    input  vec_t                             oc_op2 [NUM_COLLECTORS],
    output logic                             alu_valid,
    output warp_t                            alu_warp,
    output reg_t                             alu_dst,
    output alu_op_t                          alu_op,
    output logic [15:0]                      alu_imm,
    output logic                             alu_imm_valid,
    output mask_t                            alu_mask,
    output vec_t                             alu_src1,
    output vec_t                             alu_src2
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= dispatch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            alu_warp      <= oc_instr[sel].warp;
            alu_dst       <= oc_instr[sel].dst;
            alu_op        <= oc_instr[sel].alu_op;
            alu_imm       <= oc_instr[sel].imm;
            alu_imm_valid <= oc_instr[sel].imm_valid;
            alu_mask      <= oc_instr[sel].mask;
            alu_src1      <= oc_op1[sel];
            alu_src2      <= oc_op2[sel];  // zero when src2 unused
        end
    end

endmodule

// File: hw/oc_pkg.sv
package oc_pkg;

    localparam int num_banks     = 4;
    localparam int num_warps     = 4;
    localparam int regs_per_warp = 8;
    localparam int num_lanes     = 8;
    localparam int lane_w        = 32;
    localparam int rows_per_bank = 8;

    typedef logic [$clog2(num_warps)-1:0]     warp_t;
    typedef logic [$clog2(regs_per_warp)-1:0] reg_t;
    typedef logic [$clog2(num_banks)-1:0]     bank_t;
    typedef logic [$clog2(rows_per_bank)-1:0] row_t;
    typedef logic [num_lanes*lane_w-1:0]      vec_t;
    typedef logic [num_lanes-1:0]             mask_t;
    typedef logic [3:0]                       alu_op_t;

    typedef struct packed {
        warp_t       warp;
        reg_t        dst;
        alu_op_t     alu_op;
        logic [15:0] imm;
        logic        imm_valid;
        mask_t       mask;
    } instr_t;

    // skewed by warp so equal register numbers of different warps spread out
    function automatic bank_t bank_of(input warp_t warp, input reg_t r);
        return bank_t'(r[1:0] + warp);
    endfunction

    function automatic row_t row_of(input warp_t warp, input reg_t r);
        return {warp, r[2]};
    endfunction

    // index width for a select over n entries
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

// File: hw/oc_req_if.sv
`timescale 1ns/1ps

interface oc_req_if;

    logic            busy;
    logic            ready;       // instruction held, both operands in
    logic [1:0]      req_valid;   // one per source slot
    logic [1:0][1:0] req_bank;
    logic [1:0][2:0] req_row;
    logic            alloc;       // issue fields valid on shared wires
    logic [1:0]      grant;
    logic            dispatch;    // frees the collector

    modport collector (
        output busy, ready, req_valid, req_bank, req_row,
        input  alloc, grant, dispatch
    );

    modport control (
        input  busy, ready, req_valid, req_bank, req_row,
        output alloc, grant, dispatch
    );

endinterface

// File: hw/operand_collector_top.sv
`timescale 1ns/1ps

module operand_collector_top import oc_pkg::*; #(
    parameter int NUM_COLLECTORS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_valid,
    input  warp_t       wb_warp,
    input  reg_t        wb_reg,
    input  vec_t        wb_data,
    input  mask_t       wb_mask,
    input  logic        issue_valid,
    input  warp_t       issue_warp,
    input  reg_t        issue_src1,
    input  logic        issue_src1_valid,
    input  reg_t        issue_src2,
    input  logic        issue_src2_valid,
    input  reg_t        issue_dst,
    input  alu_op_t     issue_alu_op,
    input  logic [15:0] issue_imm,
    input  logic        issue_imm_valid,
    input  mask_t       issue_mask,
    output logic        collectors_full,
    output logic        alu_valid,
    output warp_t       alu_warp,
    output reg_t        alu_dst,
    output alu_op_t     alu_op,
    output logic [15:0] alu_imm,
    output logic        alu_imm_valid,
    output mask_t       alu_mask,
    output vec_t        alu_src1,
    output vec_t        alu_src2
);

    instr_t                           issue_instr;
    logic [num_banks-1:0]             rd_en;
    row_t                             rd_row [num_banks];
    vec_t                             bank_rd_data [num_banks];
    instr_t                           oc_instr [NUM_COLLECTORS];
    vec_t                             oc_op1 [NUM_COLLECTORS];
    vec_t                             oc_op2 [NUM_COLLECTORS];
    logic                             dispatch_valid;
    logic [idx_w(NUM_COLLECTORS)-1:0] sel;

    oc_req_if req_if [NUM_COLLECTORS] ();

    assign issue_instr = '{warp: issue_warp, dst: issue_dst, alu_op: issue_alu_op,
                           imm: issue_imm, imm_valid: issue_imm_valid, mask: issue_mask};

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        reg_bank #(.BANK_ID(b)) u_bank (
            .clk(clk), .wb_valid(wb_valid), .wb_warp(wb_warp), .wb_reg(wb_reg),
            .wb_data(wb_data), .wb_mask(wb_mask), .rd_en(rd_en[b]),
            .rd_row(rd_row[b]), .rd_data(bank_rd_data[b])
        );
    end

    for (genvar c = 0; c < NUM_COLLECTORS; c++) begin : g_oc
        collector_unit u_oc (
            .clk(clk), .rst_n(rst_n), .issue_instr(issue_instr),
            .issue_src1(issue_src1), .issue_src1_valid(issue_src1_valid),
            .issue_src2(issue_src2), .issue_src2_valid(issue_src2_valid),
            .bank_rd_data(bank_rd_data), .instr(oc_instr[c]),
            .op1(oc_op1[c]), .op2(oc_op2[c]), .req(req_if[c])
        );
    end

    collector_control #(.NUM_COLLECTORS(NUM_COLLECTORS)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .rd_en(rd_en),
        .rd_row(rd_row), .collectors_full(collectors_full),
        .dispatch_valid(dispatch_valid), .sel(sel), .req(req_if)
    );

    dispatch_stage #(.NUM_COLLECTORS(NUM_COLLECTORS)) u_disp (
        .clk(clk), .rst_n(rst_n), .dispatch_valid(dispatch_valid), .sel(sel),
        .oc_instr(oc_instr), .oc_op1(oc_op1), .oc_op2(oc_op2),
        .alu_valid(alu_valid), .alu_warp(alu_warp), .alu_dst(alu_dst),
        .alu_op(alu_op), .alu_imm(alu_imm), .alu_imm_valid(alu_imm_valid),
        .alu_mask(alu_mask), .alu_src1(alu_src1), .alu_src2(alu_src2)
    );

endmodule

// File: hw/reg_bank.sv
`timescale 1ns/1ps

module reg_bank import oc_pkg::*; #(
    parameter int BANK_ID = 0
) (
    input  logic  clk,
    input  logic  wb_valid,
    input  warp_t wb_warp,
    input  reg_t  wb_reg,
    input  vec_t  wb_data,
    input  mask_t wb_mask,
    input  logic  rd_en,
    input  row_t  rd_row,
    output vec_t  rd_data
);

    vec_t mem [rows_per_bank];
    logic wb_hit;
    row_t wb_row;

    assign wb_hit = wb_valid && (bank_of(wb_warp, wb_reg) == bank_t'(BANK_ID));
    assign wb_row = row_of(wb_warp, wb_reg);

    always_ff @(posedge clk) begin
        if (wb_hit) begin
            for (int l = 0; l < num_lanes; l++) begin
                if (wb_mask[l]) begin
                    mem[wb_row][l*lane_w +: lane_w] <= wb_data[l*lane_w +: lane_w];
                end
            end
        end
    end

    // old data on a same-row write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the operand collector testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -f flist.f --top-module oc_tb -o oc_sim
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

./obj_dir/oc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
